// ==== Bender.yml ====
package:
  name: fp_noncomp

sources:
  - files:
      - verilog/fpnc_pkg.sv
      - verilog/fp_classifier.sv
      - verilog/fp_sign_inject.sv
      - verilog/fp_compare.sv
      - verilog/fp_result_pipe.sv
      - verilog/fp_pipe_ctrl.sv
      - verilog/fp_noncomp_top.sv
  - target: test
    files:
      - dv/tb_fp_noncomp.sv

// ==== dv/tb_fp_noncomp.sv ====
// Directed testbench for the binary32 non-computational unit, with reference model and watchdog
`timescale 1ns/100ps

module tb_fp_noncomp;
  import fpnc_pkg::*;

  localparam int unsigned CLK_PERIOD = 40;
  localparam int unsigned NUM_REGS   = 2;
  localparam int unsigned TAG_W      = 4;
  localparam logic [31:0] LFSR_SEED  = 32'h0866_f244;
  localparam int unsigned N_BURST    = 40;
  // Sign injection, min/max, compare, classify, burst
  localparam int unsigned TOTAL_ITEMS = 32 + 28 + 42 + 10 + N_BURST;
  localparam longint WATCHDOG_NS = (TOTAL_ITEMS * 20 + 100) * CLK_PERIOD;

  logic               clk_i;
  logic               reset_i;
  fp_word_t           operand_a_i;
  fp_word_t           operand_b_i;
  nc_op_e             op_i;
  sub_op_e            sub_op_i;
  logic               op_mod_i;
  logic [TAG_W-1:0]   tag_i;
  logic               in_valid_i;
  logic               in_ready_o;
  nc_result_t         result_o;
  logic [TAG_W-1:0]   tag_o;
  logic               out_valid_o;
  logic               out_ready_i;

  // Scoreboard of accepted items, oldest first
  nc_result_t         exp_q[$];
  logic [TAG_W-1:0]   exp_tag_q[$];
  longint             accept_time_q[$];

  logic [31:0]        lfsr_q;
  logic [TAG_W-1:0]   next_tag;
  int                 value_errors;
  int                 other_errors;
  int                 tx_count;
  int                 rx_count;
  logic               latency_check;
  logic               watch_full;
  logic               saw_full;

  fp_noncomp_top #(
    .NumPipeRegs (NUM_REGS),
    .TagWidth    (TAG_W)
  ) i_dut (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .op_i        (op_i),
    .sub_op_i    (sub_op_i),
    .op_mod_i    (op_mod_i),
    .tag_i       (tag_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .result_o    (result_o),
    .tag_o       (tag_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // --------------------------------------------------------------------
  // Random source and reference model
  // --------------------------------------------------------------------
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] take_bits(int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic logic nan_of(fp_word_t w);
    return (w[30:23] == 8'hFF) && (w[22:0] != '0);
  endfunction

  // Quiet bit clear means signalling
  function automatic logic snan_of(fp_word_t w);
    return nan_of(w) && !w[22];
  endfunction

  // Sign-magnitude to two's complement, both zeros map to 0
  function automatic logic signed [32:0] order_key(fp_word_t w);
    logic signed [32:0] mag;
    mag = $signed({2'b00, w[30:0]});
    return w[31] ? -mag : mag;
  endfunction

  function automatic class_mask_e class_of(fp_word_t w);
    int idx;
    if (nan_of(w)) idx = w[22] ? 9 : 8;
    else if (w[30:23] == 8'hFF) idx = w[31] ? 0 : 7;
    else if (w[30:23] != 8'h00) idx = w[31] ? 1 : 6;
    else if (w[22:0] != '0) idx = w[31] ? 2 : 5;
    else idx = w[31] ? 3 : 4;
    return class_mask_e'(10'b1 << idx);
  endfunction

  function automatic nc_result_t model(nc_op_e op, sub_op_e sub, logic md,
                                       fp_word_t a, fp_word_t b);
    nc_result_t r;
    logic       any_nan;
    logic       any_snan;
    logic       lt;
    logic       eq;
    r          = '0;
    r.class_mask = class_of(a);
    any_nan    = nan_of(a) | nan_of(b);
    any_snan   = snan_of(a) | snan_of(b);
    lt         = order_key(a) < order_key(b);
    eq         = order_key(a) == order_key(b);
    case (op)
      SGNJ: begin
        case (sub)
          RNE: r.result = {b[31], a[30:0]};
          RTZ: r.result = {~b[31], a[30:0]};
          RDN: r.result = {a[31] ^ b[31], a[30:0]};
          default: r.result = a;
        endcase
      end
      MINMAX: begin
        r.status.NV = any_snan;
        if (nan_of(a) && nan_of(b)) r.result = CANONICAL_NAN;
        else if (nan_of(a)) r.result = b;
        else if (nan_of(b)) r.result = a;
        else if (eq && a[30:0] == '0) begin
          // -0 counts as below +0
          r.result = (sub == RTZ) ? {a[31] & b[31], 31'b0} : {a[31] | b[31], 31'b0};
        end else if (sub == RTZ) r.result = lt ? b : a;
        else r.result = lt ? a : b;
      end
      CMP: begin
        if (any_snan) r.status.NV = 1'b1;
        else if (sub == RNE || sub == RTZ) begin
          if (any_nan) r.status.NV = 1'b1;
          else if (sub == RNE) r.result[0] = (lt | eq) ^ md;
          else r.result[0] = lt ^ md;
        end else if (sub == RDN) begin
          r.result[0] = any_nan ? md : (eq ^ md);
        end
      end
      default: r.is_class = 1'b1;
    endcase
    return r;
  endfunction

  // --------------------------------------------------------------------
  // Checks and output monitor
  // --------------------------------------------------------------------
  task automatic check_field(string name, logic [47:0] exp_v, logic [47:0] act_v);
    assert (act_v === exp_v) else begin
      value_errors++;
      $display("[FAIL] %0t ns: %s expected %0h, got %0h", $time, name, exp_v, act_v);
    end
  endtask

  always @(posedge clk_i) begin
    nc_result_t       exp_r;
    logic [TAG_W-1:0] exp_tag;
    longint           t_acc;
    if (!reset_i && watch_full && in_valid_i && !in_ready_o) saw_full = 1'b1;
    if (!reset_i && out_valid_o && out_ready_i) begin
      rx_count++;
      assert (exp_q.size() != 0) else begin
        other_errors++;
        $display("Output item with tag %0h appeared with nothing outstanding", tag_o);
      end
      if (exp_q.size() != 0) begin
        exp_r   = exp_q.pop_front();
        exp_tag = exp_tag_q.pop_front();
        t_acc   = accept_time_q.pop_front();
        check_field("tag_o", 48'(exp_tag), 48'(tag_o));
        check_field("result_o.result", 48'(exp_r.result), 48'(result_o.result));
        check_field("result_o.status", 48'(exp_r.status), 48'(result_o.status));
        check_field("result_o.class_mask", 48'(exp_r.class_mask), 48'(result_o.class_mask));
        check_field("result_o.is_class", 48'(exp_r.is_class), 48'(result_o.is_class));
        if (latency_check) begin
          assert (($time - t_acc) / CLK_PERIOD == NUM_REGS) else begin
            other_errors++;
            $display("Item with tag %0h took %0d cycles instead of %0d", tag_o,
                     ($time - t_acc) / CLK_PERIOD, NUM_REGS);
          end
        end
      end
    end
  end

  // --------------------------------------------------------------------
  // Drivers
  // --------------------------------------------------------------------
  // Called and returns 2 ns after a rising edge
  task automatic send_item(nc_op_e op, sub_op_e sub, logic md, fp_word_t a, fp_word_t b);
    operand_a_i = a;
    operand_b_i = b;
    op_i        = op;
    sub_op_i    = sub;
    op_mod_i    = md;
    tag_i       = next_tag;
    in_valid_i  = 1'b1;
    @(posedge clk_i);
    while (!in_ready_o) @(posedge clk_i);
    exp_q.push_back(model(op, sub, md, a, b));
    exp_tag_q.push_back(next_tag);
    accept_time_q.push_back($time);
    tx_count++;
    next_tag = next_tag + 1'b1;
    #2;
    in_valid_i = 1'b0;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < 200) begin
      @(posedge clk_i);
      #2;
      n++;
    end
    assert (exp_q.size() == 0) else begin
      other_errors++;
      $display("%0d items never came out of the pipeline", exp_q.size());
    end
  endtask

  // --------------------------------------------------------------------
  // Tests
  // --------------------------------------------------------------------
  // Four edges with reset high, then one check with reset low
  task automatic run_reset();
    reset_i     = 1'b1;
    operand_a_i = '0;
    operand_b_i = '0;
    op_i        = SGNJ;
    sub_op_i    = RNE;
    op_mod_i    = 1'b0;
    tag_i       = '0;
    in_valid_i  = 1'b0;
    out_ready_i = 1'b1;
    repeat (4) begin
      @(posedge clk_i);
      #2;
      check_field("out_valid_o", 48'd0, 48'(out_valid_o));
      check_field("in_ready_o", 48'd1, 48'(in_ready_o));
    end
    reset_i = 1'b0;
    @(posedge clk_i);
    #2;
    check_field("out_valid_o", 48'd0, 48'(out_valid_o));
    check_field("in_ready_o", 48'd1, 48'(in_ready_o));
  endtask

  task automatic test_sign_inject();
    for (int s = 0; s < 4; s++) begin
      repeat (8) send_item(SGNJ, sub_op_e'(s), 1'b0, take_bits(32), take_bits(32));
    end
    wait_drain();
  endtask

  task automatic minmax_pair(fp_word_t a, fp_word_t b);
    send_item(MINMAX, RNE, 1'b0, a, b);
    send_item(MINMAX, RTZ, 1'b0, a, b);
  endtask

  task automatic test_minmax();
    repeat (8) minmax_pair(take_bits(32), take_bits(32));
    minmax_pair(32'h0000_0000, 32'h8000_0000);
    minmax_pair(32'h8000_0000, 32'h0000_0000);
    minmax_pair(32'h3F80_0000, 32'hFFC0_0000);
    minmax_pair(32'h7FC1_2345, 32'hC000_0000);
    minmax_pair(32'h7FC0_0001, 32'hFFC0_0000);
    minmax_pair(32'h7F80_0001, 32'h3F80_0000);
    wait_drain();
  endtask

  task automatic cmp_pair(fp_word_t a, fp_word_t b);
    for (int s = 0; s < 3; s++) begin
      send_item(CMP, sub_op_e'(s), 1'b0, a, b);
      send_item(CMP, sub_op_e'(s), 1'b1, a, b);
    end
  endtask

  task automatic test_compare();
    cmp_pair(32'h3F80_0000, 32'h4000_0000);
    cmp_pair(32'h4000_0000, 32'h3F80_0000);
    cmp_pair(32'hBF80_0000, 32'h3F80_0000);
    cmp_pair(32'h3FC0_0000, 32'h3FC0_0000);
    cmp_pair(32'h0000_0000, 32'h8000_0000);
    cmp_pair(32'h7FC0_0000, 32'h3F80_0000);
    cmp_pair(32'h3F80_0000, 32'h7F80_0001);
    wait_drain();
  endtask

  // One operand per class, from bit 0 to bit 9
  task automatic test_classify();
    send_item(CLASSIFY, RNE, 1'b0, 32'hFF80_0000, '0);
    send_item(CLASSIFY, RNE, 1'b0, 32'hBF80_0000, '0);
    send_item(CLASSIFY, RNE, 1'b0, 32'h8000_0001, '0);
    send_item(CLASSIFY, RNE, 1'b0, 32'h8000_0000, '0);
    send_item(CLASSIFY, RNE, 1'b0, 32'h0000_0000, '0);
    send_item(CLASSIFY, RNE, 1'b0, 32'h0040_0000, '0);
    send_item(CLASSIFY, RNE, 1'b0, 32'h3F80_0000, '0);
    send_item(CLASSIFY, RNE, 1'b0, 32'h7F80_0000, '0);
    send_item(CLASSIFY, RNE, 1'b0, 32'h7F80_0001, '0);
    send_item(CLASSIFY, RNE, 1'b0, 32'h7FC0_0000, '0);
    wait_drain();
  endtask

  task automatic test_backpressure();
    fp_word_t burst_a [N_BURST];
    fp_word_t burst_b [N_BURST];
    nc_op_e   burst_op [N_BURST];
    sub_op_e  burst_sub [N_BURST];
    logic     burst_mod [N_BURST];
    logic     burst_done;
    int       low_left;
    int       tx_start;
    // Stimulus drawn up front so the ready process owns the LFSR
    for (int i = 0; i < N_BURST; i++) begin
      burst_a[i]   = take_bits(32);
      burst_b[i]   = take_bits(32);
      burst_op[i]  = nc_op_e'(take_bits(2));
      burst_sub[i] = sub_op_e'(take_bits(2));
      burst_mod[i] = 1'(take_bits(1));
    end
    latency_check = 1'b0;
    watch_full    = 1'b1;
    saw_full      = 1'b0;
    burst_done    = 1'b0;
    low_left      = 0;
    tx_start      = tx_count;
    fork
      begin
        for (int i = 0; i < N_BURST; i++) begin
          send_item(burst_op[i], burst_sub[i], burst_mod[i], burst_a[i], burst_b[i]);
        end
        burst_done = 1'b1;
      end
      begin
        while (!burst_done) begin
          @(posedge clk_i);
          #2;
          if (low_left > 0) begin
            out_ready_i = 1'b0;
            low_left--;
          end else if (take_bits(3) == 0) begin
            // Long stall to fill every stage
            out_ready_i = 1'b0;
            low_left = 5;
          end else begin
            out_ready_i = 1'(take_bits(1));
          end
        end
      end
    join
    out_ready_i = 1'b1;
    wait_drain();
    watch_full    = 1'b0;
    latency_check = 1'b1;
    assert (saw_full) else begin
      other_errors++;
      $display("in_ready_o never dropped while the pipeline was stalled");
    end
    assert (tx_count - tx_start == N_BURST) else begin
      other_errors++;
      $display("Only %0d of %0d burst items were accepted", tx_count - tx_start, N_BURST);
    end
  endtask

  // --------------------------------------------------------------------
  // Main sequence and watchdog
  // --------------------------------------------------------------------
  initial begin
    lfsr_q        = LFSR_SEED;
    next_tag      = '0;
    value_errors  = 0;
    other_errors  = 0;
    tx_count      = 0;
    rx_count      = 0;
    latency_check = 1'b1;
    watch_full    = 1'b0;
    saw_full      = 1'b0;
    run_reset();
    test_sign_inject();
    test_minmax();
    test_compare();
    test_classify();
    test_backpressure();
    assert (rx_count == tx_count) else begin
      other_errors++;
      $display("Sent %0d items but received %0d", tx_count, rx_count);
    end
    $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before the tests finished");
    $display("Simulation failed");
    $finish;
  end

endmodule

// ==== flist.f ====
verilog/fpnc_pkg.sv
verilog/fp_classifier.sv
verilog/fp_sign_inject.sv
verilog/fp_compare.sv
verilog/fp_result_pipe.sv
verilog/fp_pipe_ctrl.sv
verilog/fp_noncomp_top.sv
dv/tb_fp_noncomp.sv

// ==== verilog/fp_classifier.sv ====
// Operand class decode for both operands and class mask of operand A
`timescale 1ns/100ps

module fp_classifier (
  input  fpnc_pkg::fp_word_t    operand_a_i,
  input  fpnc_pkg::fp_word_t    operand_b_i,
  output fpnc_pkg::fp_info_t    info_a_o,
  output fpnc_pkg::fp_info_t    info_b_o,
  output fpnc_pkg::class_mask_e class_mask_o
);
  import fpnc_pkg::*;

  fp_fields_t a_fields;

  // Decode one word into its class flags
  function automatic fp_info_t decode(fp_word_t word);
    fp_fields_t f;
    logic       exp_ones;
    logic       exp_zero;
    logic       man_zero;
    fp_info_t   info;
    f        = word;
    exp_ones = &f.exponent;
    exp_zero = ~|f.exponent;
    man_zero = ~|f.mantissa;
    info.is_normal    = !exp_ones && !exp_zero;
    info.is_subnormal = exp_zero && !man_zero;
    info.is_zero      = exp_zero && man_zero;
    info.is_inf       = exp_ones && man_zero;
    info.is_nan       = exp_ones && !man_zero;
    // Quiet bit is the mantissa MSB
    info.is_signalling = info.is_nan && !f.mantissa[MAN_BITS-1];
    info.is_quiet      = info.is_nan && f.mantissa[MAN_BITS-1];
    return info;
  endfunction

  assign info_a_o = decode(operand_a_i);
  assign info_b_o = decode(operand_b_i);
  assign a_fields = operand_a_i;

  // ---------------------------------------------------------------------
  // Class mask of operand A
  // ---------------------------------------------------------------------
  always_comb begin
    if (info_a_o.is_normal) begin
      class_mask_o = a_fields.sign ? NEGNORM : POSNORM;
    end else if (info_a_o.is_subnormal) begin
      class_mask_o = a_fields.sign ? NEGSUBNORM : POSSUBNORM;
    end else if (info_a_o.is_zero) begin
      class_mask_o = a_fields.sign ? NEGZERO : POSZERO;
    end else if (info_a_o.is_inf) begin
      class_mask_o = a_fields.sign ? NEGINF : POSINF;
    end else begin
      // Only NaN is left, sign does not matter
      class_mask_o = info_a_o.is_signalling ? SNAN : QNAN;
    end
  end

endmodule

// ==== verilog/fp_compare.sv ====
// Shared ordering logic, min/max result and flags, LE/LT/EQ comparison result and flags
`timescale 1ns/100ps

module fp_compare (
  input  fpnc_pkg::fp_word_t operand_a_i,
  input  fpnc_pkg::fp_word_t operand_b_i,
  input  fpnc_pkg::fp_info_t info_a_i,
  input  fpnc_pkg::fp_info_t info_b_i,
  input  fpnc_pkg::sub_op_e  sub_op_i,
  input  logic               op_mod_i,
  output fpnc_pkg::fp_word_t minmax_result_o,
  output fpnc_pkg::status_t  minmax_status_o,
  output fpnc_pkg::fp_word_t cmp_result_o,
  output fpnc_pkg::status_t  cmp_status_o
);
  import fpnc_pkg::*;

  fp_fields_t a_fields;
  fp_fields_t b_fields;
  logic       any_nan;
  logic       any_snan;
  logic       a_smaller;
  logic       equal;

  assign a_fields = operand_a_i;
  assign b_fields = operand_b_i;

  // ---------------------------------------------------------------------
  // Ordering
  // ---------------------------------------------------------------------
  assign any_nan  = info_a_i.is_nan | info_b_i.is_nan;
  assign any_snan = info_a_i.is_signalling | info_b_i.is_signalling;

  // +0 and -0 compare equal
  assign equal = (operand_a_i == operand_b_i) || (info_a_i.is_zero && info_b_i.is_zero);

  // Unsigned magnitude compare, flipped when a negative sign is involved
  assign a_smaller = (operand_a_i < operand_b_i) ^ (a_fields.sign | b_fields.sign);

  // ---------------------------------------------------------------------
  // Minimum / maximum
  // ---------------------------------------------------------------------
  always_comb begin
    minmax_status_o    = '0;
    // Quiet comparison, only sNaN is invalid
    minmax_status_o.NV = any_snan;
    if (info_a_i.is_nan && info_b_i.is_nan) begin
      minmax_result_o = CANONICAL_NAN;
    end else if (info_a_i.is_nan) begin
      minmax_result_o = operand_b_i;
    end else if (info_b_i.is_nan) begin
      minmax_result_o = operand_a_i;
    end else if (sub_op_i == RTZ) begin
      // MAX
      minmax_result_o = a_smaller ? operand_b_i : operand_a_i;
    end else begin
      // MIN, also taken for unused codes
      minmax_result_o = a_smaller ? operand_a_i : operand_b_i;
    end
  end

  // ---------------------------------------------------------------------
  // Comparisons
  // ---------------------------------------------------------------------
  // Boolean result sits in bit 0, op_mod_i inverts it
  always_comb begin
    cmp_result_o = '0;
    cmp_status_o = '0;
    if (any_snan) begin
      cmp_status_o.NV = 1'b1;
    end else begin
      case (sub_op_i)
        // LE, signalling on any NaN
        RNE: begin
          if (any_nan) cmp_status_o.NV = 1'b1;
          else cmp_result_o[0] = (a_smaller | equal) ^ op_mod_i;
        end
        // LT, signalling on any NaN
        RTZ: begin
          if (any_nan) cmp_status_o.NV = 1'b1;
          else cmp_result_o[0] = (a_smaller & ~equal) ^ op_mod_i;
        end
        // EQ, quiet NaN is simply unequal
        RDN: begin
          if (any_nan) cmp_result_o[0] = op_mod_i;
          else cmp_result_o[0] = equal ^ op_mod_i;
        end
        default: cmp_result_o = '0;
      endcase
    end
  end

endmodule

// ==== verilog/fp_noncomp_top.sv ====
// Top level of the binary32 non-computational unit, datapath and pipeline control
`timescale 1ns/100ps

module fp_noncomp_top #(
  parameter int unsigned NumPipeRegs = 2,
  parameter int unsigned TagWidth    = 4
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  // Input side
  input  fpnc_pkg::fp_word_t   operand_a_i,
  input  fpnc_pkg::fp_word_t   operand_b_i,
  input  fpnc_pkg::nc_op_e     op_i,
  input  fpnc_pkg::sub_op_e    sub_op_i,
  input  logic                 op_mod_i,
  input  logic [TagWidth-1:0]  tag_i,
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  // Output side
  output fpnc_pkg::nc_result_t result_o,
  output logic [TagWidth-1:0]  tag_o,
  output logic                 out_valid_o,
  input  logic                 out_ready_i
);
  import fpnc_pkg::*;

  fp_info_t                info_a;
  fp_info_t                info_b;
  class_mask_e             class_mask;
  fp_word_t                sgnj_result;
  fp_word_t                minmax_result;
  fp_word_t                cmp_result;
  status_t                 minmax_status;
  status_t                 cmp_status;
  logic [NumPipeRegs-1:0]  stage_en;

  // ---------------------------------------------------------------------
  // Combinational datapath
  // ---------------------------------------------------------------------
  fp_classifier i_classifier (
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .info_a_o     (info_a),
    .info_b_o     (info_b),
    .class_mask_o (class_mask)
  );

  fp_sign_inject i_sign_inject (
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .sub_op_i    (sub_op_i),
    .result_o    (sgnj_result)
  );

  fp_compare i_compare (
    .operand_a_i     (operand_a_i),
    .operand_b_i     (operand_b_i),
    .info_a_i        (info_a),
    .info_b_i        (info_b),
    .sub_op_i        (sub_op_i),
    .op_mod_i        (op_mod_i),
    .minmax_result_o (minmax_result),
    .minmax_status_o (minmax_status),
    .cmp_result_o    (cmp_result),
    .cmp_status_o    (cmp_status)
  );

  // ---------------------------------------------------------------------
  // Output registers and their control
  // ---------------------------------------------------------------------
  fp_result_pipe #(
    .NumPipeRegs (NumPipeRegs),
    .TagWidth    (TagWidth)
  ) i_result_pipe (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .op_i            (op_i),
    .sgnj_result_i   (sgnj_result),
    .minmax_result_i (minmax_result),
    .cmp_result_i    (cmp_result),
    .minmax_status_i (minmax_status),
    .cmp_status_i    (cmp_status),
    .class_mask_i    (class_mask),
    .tag_i           (tag_i),
    .stage_en_i      (stage_en),
    .result_o        (result_o),
    .tag_o           (tag_o)
  );

  fp_pipe_ctrl #(
    .NumPipeRegs (NumPipeRegs)
  ) i_pipe_ctrl (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .in_valid_i  (in_valid_i),
    .out_ready_i (out_ready_i),
    .in_ready_o  (in_ready_o),
    .out_valid_o (out_valid_o),
    .stage_en_o  (stage_en)
  );

endmodule

// ==== verilog/fp_pipe_ctrl.sv ====
// Per-stage valid bits, backward ready chain and register stage enables
`timescale 1ns/100ps

module fp_pipe_ctrl #(
  parameter int unsigned NumPipeRegs = 2
) (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   in_valid_i,
  input  logic                   out_ready_i,
  output logic                   in_ready_o,
  output logic                   out_valid_o,
  output logic [NumPipeRegs-1:0] stage_en_o
);

  // Index i is the valid/ready pair in front of register stage i
  logic [0:NumPipeRegs] valid_q;
  logic [0:NumPipeRegs] ready;

  // Upstream side feeds stage zero
  assign valid_q[0] = in_valid_i;
  assign in_ready_o = ready[0];

  // Downstream side closes the chain
  assign ready[NumPipeRegs] = out_ready_i;
  assign out_valid_o        = valid_q[NumPipeRegs];

  // ---------------------------------------------------------------------
  // Stages
  // ---------------------------------------------------------------------
  for (genvar i = 0; i < NumPipeRegs; i++) begin : gen_stage
    // Advance when the next stage moves on or only holds a bubble
    assign ready[i] = ready[i+1] | ~valid_q[i+1];

    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        valid_q[i+1] <= 1'b0;
      end else if (ready[i]) begin
        valid_q[i+1] <= valid_q[i];
      end
    end
  end

  // Load a stage only for a real item that can move
  always_comb begin
    stage_en_o = '0;
    for (int i = 0; i < NumPipeRegs; i++) begin
      stage_en_o[i] = ready[i] & valid_q[i];
    end
  end

endmodule

// ==== verilog/fp_result_pipe.sv ====
// Result selection per operation and the enabled result/tag register stages
`timescale 1ns/100ps

module fp_result_pipe #(
  parameter int unsigned NumPipeRegs = 2,
  parameter int unsigned TagWidth    = 4
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  fpnc_pkg::nc_op_e      op_i,
  input  fpnc_pkg::fp_word_t    sgnj_result_i,
  input  fpnc_pkg::fp_word_t    minmax_result_i,
  input  fpnc_pkg::fp_word_t    cmp_result_i,
  input  fpnc_pkg::status_t     minmax_status_i,
  input  fpnc_pkg::status_t     cmp_status_i,
  input  fpnc_pkg::class_mask_e class_mask_i,
  input  logic [TagWidth-1:0]   tag_i,
  input  logic [NumPipeRegs-1:0] stage_en_i,
  output fpnc_pkg::nc_result_t  result_o,
  output logic [TagWidth-1:0]   tag_o
);
  import fpnc_pkg::*;

  // Index i holds the item after i register stages
  nc_result_t [0:NumPipeRegs]               res_q;
  logic       [0:NumPipeRegs][TagWidth-1:0] tag_q;

  // ---------------------------------------------------------------------
  // Stage zero, combinational selection
  // ---------------------------------------------------------------------
  always_comb begin
    res_q[0].class_mask = class_mask_i;
    res_q[0].is_class   = (op_i == CLASSIFY);
    case (op_i)
      SGNJ: begin
        res_q[0].result = sgnj_result_i;
        // Sign injection never raises flags
        res_q[0].status = '0;
      end
      MINMAX: begin
        res_q[0].result = minmax_result_i;
        res_q[0].status = minmax_status_i;
      end
      CMP: begin
        res_q[0].result = cmp_result_i;
        res_q[0].status = cmp_status_i;
      end
      default: begin
        // CLASSIFY, answer lives in the class mask
        res_q[0].result = '0;
        res_q[0].status = '0;
      end
    endcase
  end

  assign tag_q[0] = tag_i;

  // ---------------------------------------------------------------------
  // Register stages, loaded only on their enable
  // ---------------------------------------------------------------------
  for (genvar i = 0; i < NumPipeRegs; i++) begin : gen_stage
    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        res_q[i+1] <= '0;
        tag_q[i+1] <= '0;
      end else if (stage_en_i[i]) begin
        res_q[i+1] <= res_q[i];
        tag_q[i+1] <= tag_q[i];
      end
    end
  end

  assign result_o = res_q[NumPipeRegs];
  assign tag_o    = tag_q[NumPipeRegs];

endmodule

// ==== verilog/fp_sign_inject.sv ====
// Sign injection (SGNJ, SGNJN, SGNJX) and raw passthrough of operand A
`timescale 1ns/100ps

module fp_sign_inject (
  input  fpnc_pkg::fp_word_t operand_a_i,
  input  fpnc_pkg::fp_word_t operand_b_i,
  input  fpnc_pkg::sub_op_e  sub_op_i,
  output fpnc_pkg::fp_word_t result_o
);
  import fpnc_pkg::*;

  fp_fields_t a_fields;
  fp_fields_t b_fields;
  fp_fields_t sgnj;

  assign a_fields = operand_a_i;
  assign b_fields = operand_b_i;

  // Exponent and mantissa always come from A
  always_comb begin
    sgnj = a_fields;
    case (sub_op_i)
      // SGNJ
      RNE: sgnj.sign = b_fields.sign;
      // SGNJN
      RTZ: sgnj.sign = ~b_fields.sign;
      // SGNJX
      RDN: sgnj.sign = a_fields.sign ^ b_fields.sign;
      // RUP and unused codes pass A through
      default: sgnj = a_fields;
    endcase
  end

  assign result_o = sgnj;

endmodule

// ==== verilog/fpnc_pkg.sv ====
// Binary32 field widths, operand/status/info types, class mask, operation codes, result record

package fpnc_pkg;

  // --------------------------------------------------------------------
  // Binary32 format
  // --------------------------------------------------------------------
  localparam int unsigned FP_WIDTH = 32;
  localparam int unsigned EXP_BITS = 8;
  localparam int unsigned MAN_BITS = 23;

  // One binary32 value as raw bits
  typedef logic [FP_WIDTH-1:0] fp_word_t;

  // Field view that overlays fp_word_t
  typedef struct packed {
    logic                sign;
    logic [EXP_BITS-1:0] exponent;
    logic [MAN_BITS-1:0] mantissa;
  } fp_fields_t;

  // Positive quiet NaN with only the top mantissa bit set
  localparam fp_word_t CANONICAL_NAN = 32'h7FC0_0000;

  // Operand class flags
  typedef struct packed {
    logic is_normal;
    logic is_subnormal;
    logic is_zero;
    logic is_inf;
    logic is_nan;
    logic is_signalling;
    logic is_quiet;
  } fp_info_t;

  // IEEE exception flags, usual order
  typedef struct packed {
    logic NV;
    logic DZ;
    logic OF;
    logic UF;
    logic NX;
  } status_t;

  // One-hot class mask, bit 0 is negative infinity
  typedef enum logic [9:0] {
    NEGINF     = 10'b00_0000_0001,
    NEGNORM    = 10'b00_0000_0010,
    NEGSUBNORM = 10'b00_0000_0100,
    NEGZERO    = 10'b00_0000_1000,
    POSZERO    = 10'b00_0001_0000,
    POSSUBNORM = 10'b00_0010_0000,
    POSNORM    = 10'b00_0100_0000,
    POSINF     = 10'b00_1000_0000,
    SNAN       = 10'b01_0000_0000,
    QNAN       = 10'b10_0000_0000
  } class_mask_e;

  // --------------------------------------------------------------------
  // Operation coding
  // --------------------------------------------------------------------
  typedef enum logic [1:0] {
    SGNJ     = 2'd0,
    MINMAX   = 2'd1,
    CMP      = 2'd2,
    CLASSIFY = 2'd3
  } nc_op_e;

  // Rounding-mode field, reused to select the sub-operation
  typedef enum logic [2:0] {
    RNE = 3'b000,
    RTZ = 3'b001,
    RDN = 3'b010,
    RUP = 3'b011
  } sub_op_e;

  // Result record carried through the output registers
  typedef struct packed {
    fp_word_t    result;
    status_t     status;
    class_mask_e class_mask;
    logic        is_class;
  } nc_result_t;

endpackage
